//--- logic/stack_defines.svh
`ifndef STACK_DEFINES_SVH
`define STACK_DEFINES_SVH

// datapath and stack sizing.
`define STACK_WIDTH    32
`define STACK_DEPTH    8
`define STACK_PTR_BITS 4

// wishbone register map, word addresses.
`define REG_INSTR   4'd0
`define REG_STATUS  4'd1
`define REG_TOP     4'd2
`define REG_CONTROL 4'd3

`endif

//--- logic/stack_pkg.sv
`default_nettype none

`include "stack_defines.svh"

package stack_pkg;

    // instruction bits 31 to 24.
    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_PUSH = 8'h01,
        OP_POP  = 8'h02,
        OP_DUP  = 8'h03,
        OP_ADD  = 8'h10,
        OP_SUB  = 8'h11,
        OP_AND  = 8'h12,
        OP_OR   = 8'h13,
        OP_XOR  = 8'h14,
        OP_SHL  = 8'h15
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5,
        ALU_SHL  = 3'd6
    } alu_op_e;

    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        POP_B = 3'd1,
        POP_A = 3'd2,
        EXEC  = 3'd3,
        WRITE = 3'd4
    } ctl_state_e;

    ////////////////////
    // bundles.

    typedef struct packed {
        alu_op_e                 alu_op;
        logic [1:0]              pops;
        logic                    pushes_result;
        logic                    push_const;
        logic                    dup;
        logic [`STACK_WIDTH-1:0] const_val;
    } decode_t;

    typedef struct packed {
        logic                    push;
        logic                    pop;
        logic                    clear;
        logic [`STACK_WIDTH-1:0] data;
    } stack_cmd_t;

    typedef struct packed {
        logic [`STACK_WIDTH-1:0]    top;
        logic [`STACK_PTR_BITS-1:0] depth;
        logic                       full;
        logic                       empty;
    } stack_stat_t;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [3:0]              adr;
        logic [`STACK_WIDTH-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                    ack;
        logic [`STACK_WIDTH-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- logic/opcode_decoder.sv
`default_nettype none

`include "stack_defines.svh"

module opcode_decoder (
    input  logic [`STACK_WIDTH-1:0] instr,
    output stack_pkg::decode_t      dec
);

    import stack_pkg::*;

    localparam int IMM_BITS = 24;

    opcode_e opcode;

    assign opcode = opcode_e'(instr[31:24]);

    always_comb begin
        dec = '0;
        dec.alu_op = ALU_PASS;

        case (opcode)
            OP_PUSH: begin
                dec.pushes_result = 1'b1;
                dec.push_const = 1'b1;
                dec.const_val = {{(`STACK_WIDTH - IMM_BITS){1'b0}}, instr[IMM_BITS-1:0]};
            end
            OP_POP: begin
                dec.pops = 2'd1;
            end
            OP_DUP: begin
                dec.pushes_result = 1'b1;
                dec.dup = 1'b1;
            end
            OP_ADD: dec.alu_op = ALU_ADD;
            OP_SUB: dec.alu_op = ALU_SUB;
            OP_AND: dec.alu_op = ALU_AND;
            OP_OR:  dec.alu_op = ALU_OR;
            OP_XOR: dec.alu_op = ALU_XOR;
            OP_SHL: dec.alu_op = ALU_SHL;
            // nop and anything unknown fall through here.
            default: ;
        endcase

        // every alu opcode takes two operands and leaves one result.
        if (dec.alu_op != ALU_PASS) begin
            dec.pops = 2'd2;
            dec.pushes_result = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/operand_stack.sv
`default_nettype none

`include "stack_defines.svh"

module operand_stack (
    input  logic                   clk,
    input  logic                   reset,
    input  stack_pkg::stack_cmd_t  cmd,
    output stack_pkg::stack_stat_t stat
);

    localparam int IDX_W = $clog2(`STACK_DEPTH);
    localparam int PTR_W = `STACK_PTR_BITS;

    logic [`STACK_WIDTH-1:0] mem [`STACK_DEPTH];
    logic [PTR_W-1:0]        ptr;
    logic [`STACK_WIDTH-1:0] top_q;
    logic                    full;
    logic                    empty;
    logic                    do_push;
    logic                    do_pop;
    logic [IDX_W-1:0]        wr_idx;
    logic [IDX_W-1:0]        below_idx;

    assign full = (ptr == PTR_W'(`STACK_DEPTH));
    assign empty = (ptr == '0);

    // clear wins over pop, pop wins over push.
    assign do_pop = cmd.pop && !empty && !cmd.clear;
    assign do_push = cmd.push && !full && !cmd.clear && !cmd.pop;

    assign wr_idx = IDX_W'(ptr);
    assign below_idx = IDX_W'(ptr - PTR_W'(2));

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
            top_q <= '0;
        end else if (cmd.clear) begin
            ptr <= '0;
            top_q <= '0;
        end else if (do_pop) begin
            ptr <= ptr - PTR_W'(1);
            // the entry under the old top becomes visible, or zero when none is left.
            top_q <= (ptr >= PTR_W'(2)) ? mem[below_idx] : '0;
        end else if (do_push) begin
            ptr <= ptr + PTR_W'(1);
            top_q <= cmd.data;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_idx] <= cmd.data;
        end
    end

    assign stat = '{top: top_q, depth: ptr, full: full, empty: empty};

endmodule

`default_nettype wire

//--- logic/stack_alu.sv
`default_nettype none

`include "stack_defines.svh"

module stack_alu (
    input  stack_pkg::alu_op_e      op,
    input  logic [`STACK_WIDTH-1:0] a,
    input  logic [`STACK_WIDTH-1:0] b,
    output logic [`STACK_WIDTH-1:0] result
);

    import stack_pkg::*;

    localparam int SHIFT_W = $clog2(`STACK_WIDTH);

    logic [SHIFT_W-1:0] shamt;

    // only the low bits of b count as a shift distance.
    assign shamt = b[SHIFT_W-1:0];

    ////////////////////
    // a op b, low word only.

    always_comb begin
        case (op)
            ALU_PASS: result = a;
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SHL:  result = a << shamt;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/host_regs.sv
`default_nettype none

`include "stack_defines.svh"

module host_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  stack_pkg::wb_req_t     wb_req,
    output stack_pkg::wb_rsp_t     wb_rsp,
    input  logic                   busy,
    input  logic                   error,
    input  stack_pkg::stack_stat_t stat,
    output logic                   issue,
    output logic [`STACK_WIDTH-1:0] instr,
    output logic                   clear
);

    logic                    req;
    logic                    instr_wr;
    logic                    accept;
    logic                    ack_q;
    logic [`STACK_WIDTH-1:0] rd_q;
    logic [`STACK_WIDTH-1:0] status_word;

    // a request already acked this cycle is the host's old one.
    assign req = wb_req.cyc && wb_req.stb && !ack_q;
    assign instr_wr = req && wb_req.we && (wb_req.adr == `REG_INSTR);
    assign accept = instr_wr && !busy;

    always_comb begin
        status_word = '0;
        status_word[0] = busy;
        status_word[1] = error;
        status_word[11:8] = stat.depth;
    end

    ////////////////////
    // handshake.

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
            issue <= 1'b0;
            clear <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            issue <= 1'b0;
            clear <= 1'b0;
            if (instr_wr) begin
                // held off until the execution unit is idle.
                ack_q <= accept;
                issue <= accept;
            end else if (req) begin
                ack_q <= 1'b1;
                if (wb_req.we && (wb_req.adr == `REG_CONTROL)) begin
                    clear <= wb_req.dat[0];
                end
            end
        end
    end

    ////////////////////
    // data.

    always_ff @(posedge clk) begin
        if (accept) begin
            instr <= wb_req.dat;
        end
        if (req && !wb_req.we) begin
            case (wb_req.adr)
                `REG_INSTR:  rd_q <= instr;
                `REG_STATUS: rd_q <= status_word;
                `REG_TOP:    rd_q <= stat.top;
                default:     rd_q <= '0;
            endcase
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rd_q};

endmodule

`default_nettype wire

//--- logic/exec_control.sv
`default_nettype none

`include "stack_defines.svh"

module exec_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue,
    input  logic                    clear,
    input  stack_pkg::decode_t      dec,
    input  stack_pkg::stack_stat_t  stat,
    input  logic [`STACK_WIDTH-1:0] alu_result,
    output stack_pkg::alu_op_e      alu_op,
    output logic [`STACK_WIDTH-1:0] operand_a,
    output logic [`STACK_WIDTH-1:0] operand_b,
    output stack_pkg::stack_cmd_t   cmd,
    output logic                    busy,
    output logic                    error
);

    import stack_pkg::*;

    localparam int PTR_W = `STACK_PTR_BITS;

    ctl_state_e              state;
    logic [`STACK_WIDTH-1:0] result_q;
    logic [PTR_W-1:0]        need;
    logic [PTR_W-1:0]        remain;
    logic                    underflow;
    logic                    overflow;

    ////////////////////
    // depth checks at issue.

    always_comb begin
        // dup pops nothing but still needs one entry to copy.
        need = dec.dup ? PTR_W'(1) : PTR_W'(dec.pops);
        remain = stat.depth - PTR_W'(dec.pops);
        underflow = (stat.depth < need);
        overflow = dec.pushes_result && (remain == PTR_W'(`STACK_DEPTH));
    end

    ////////////////////
    // sequencing.

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            state <= IDLE;
            error <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (issue) begin
                        if (underflow || overflow) begin
                            error <= 1'b1;
                        end else if (dec.pops != 2'd0) begin
                            state <= POP_B;
                        end else if (dec.pushes_result) begin
                            state <= WRITE;
                        end
                    end
                end
                POP_B:   state <= (dec.pops == 2'd2) ? POP_A : IDLE;
                POP_A:   state <= EXEC;
                EXEC:    state <= WRITE;
                WRITE:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // operands and result, sampled as the fsm walks through the states.
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (issue) begin
                    alu_op <= dec.alu_op;
                    result_q <= dec.push_const ? dec.const_val : stat.top;
                end
            end
            POP_B:   operand_b <= stat.top;
            POP_A:   operand_a <= stat.top;
            EXEC:    result_q <= alu_result;
            default: ;
        endcase
    end

    always_comb begin
        cmd = '0;
        cmd.clear = clear;
        cmd.pop = (state == POP_B) || (state == POP_A);
        cmd.push = (state == WRITE);
        cmd.data = result_q;
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

//--- logic/stack_machine_top.sv
`default_nettype none

`include "stack_defines.svh"

module stack_machine_top (
    input  logic               clk,
    input  logic               reset,
    input  stack_pkg::wb_req_t wb_req,
    output stack_pkg::wb_rsp_t wb_rsp
);

    import stack_pkg::*;

    logic                    busy;
    logic                    error;
    logic                    issue;
    logic                    clear;
    logic [`STACK_WIDTH-1:0] instr;
    decode_t                 dec;
    stack_stat_t             stat;
    stack_cmd_t              cmd;
    alu_op_e                 alu_op;
    logic [`STACK_WIDTH-1:0] operand_a;
    logic [`STACK_WIDTH-1:0] operand_b;
    logic [`STACK_WIDTH-1:0] alu_result;

    host_regs host_regs (
        .clk(clk),
        .reset(reset),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .busy(busy),
        .error(error),
        .stat(stat),
        .issue(issue),
        .instr(instr),
        .clear(clear)
    );

    opcode_decoder opcode_decoder (
        .instr(instr),
        .dec(dec)
    );

    exec_control exec_control (
        .clk(clk),
        .reset(reset),
        .issue(issue),
        .clear(clear),
        .dec(dec),
        .stat(stat),
        .alu_result(alu_result),
        .alu_op(alu_op),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .cmd(cmd),
        .busy(busy),
        .error(error)
    );

    operand_stack operand_stack (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .stat(stat)
    );

    stack_alu stack_alu (
        .op(alu_op),
        .a(operand_a),
        .b(operand_b),
        .result(alu_result)
    );

endmodule

`default_nettype wire

//--- verif/wb_host_tasks.svh
`ifndef WB_HOST_TASKS_SVH
`define WB_HOST_TASKS_SVH

// one classic write, held until ack.
task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
    logic acked;
    acked = 1'b0;
    ack_cycles = 0;
    @(posedge clk);
    #DRIVE_DELAY;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = data;
    while (!acked) begin
        @(posedge clk);
        #DRIVE_DELAY;
        acked = wb_rsp.ack;
        ack_cycles++;
        if (!acked && ack_cycles >= ACK_TIMEOUT) begin
            abort_run("timeout while waiting for a write acknowledge");
        end
    end
    wb_req = '0;
endtask

// one classic read, data taken with the ack.
task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
    logic acked;
    int   cycles;
    acked = 1'b0;
    cycles = 0;
    @(posedge clk);
    #DRIVE_DELAY;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = 1'b0;
    wb_req.adr = adr;
    wb_req.dat = '0;
    while (!acked) begin
        @(posedge clk);
        #DRIVE_DELAY;
        acked = wb_rsp.ack;
        cycles++;
        if (!acked && cycles >= ACK_TIMEOUT) begin
            abort_run("timeout while waiting for a read acknowledge");
        end
    end
    data = wb_rsp.dat;
    wb_req = '0;
endtask

// polls status until the busy bit drops.
task automatic wait_idle(output logic [31:0] status);
    int polls;
    polls = 0;
    wb_read(`REG_STATUS, status);
    while (status[0]) begin
        polls++;
        if (polls >= IDLE_TIMEOUT) begin
            abort_run("timeout while waiting for the busy bit to clear");
        end
        wb_read(`REG_STATUS, status);
    end
endtask

`endif

//--- verif/stack_machine_tb.sv
`default_nettype none

`include "stack_defines.svh"

module stack_machine_tb;

    import stack_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 5;
    localparam int RESET_CYCLES = 16;
    localparam int ACK_TIMEOUT = 50;
    localparam int IDLE_TIMEOUT = 50;
    localparam opcode_e ARITH_OPS [6] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL};

    logic        clk;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    int          ack_cycles;

    // reference stack with the top as the last element.
    logic [31:0] model [$];
    logic        model_error;

    stack_machine_top dut (
        .clk(clk),
        .reset(reset),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping after the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("ERROR: %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopping after the first failure");
        end
    endtask

    `include "wb_host_tasks.svh"

    ////////////////////
    // reference model.

    function automatic logic [31:0] expected_result(input opcode_e op, input logic [31:0] a,
                                                    input logic [31:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SHL:  return a << b[4:0];
            default: return 32'h0;
        endcase
    endfunction

    task automatic model_apply(input opcode_e op, input logic [23:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        case (op)
            OP_PUSH: begin
                if (model.size() == `STACK_DEPTH) model_error = 1'b1;
                else model.push_back({8'h00, imm});
            end
            OP_POP: begin
                if (model.size() == 0) model_error = 1'b1;
                else b = model.pop_back();
            end
            OP_DUP: begin
                if (model.size() == 0 || model.size() == `STACK_DEPTH) model_error = 1'b1;
                else model.push_back(model[$]);
            end
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL: begin
                if (model.size() < 2) begin
                    model_error = 1'b1;
                end else begin
                    b = model.pop_back();
                    a = model.pop_back();
                    model.push_back(expected_result(op, a, b));
                end
            end
            default: ;
        endcase
    endtask

    function automatic logic [23:0] rand_imm();
        return 24'($urandom);
    endfunction

    task automatic check_state(input string name);
        logic [31:0] status;
        logic [31:0] top;
        logic [31:0] exp_status;
        logic [31:0] exp_top;
        exp_status = '0;
        exp_status[1] = model_error;
        exp_status[11:8] = 4'(model.size());
        exp_top = (model.size() != 0) ? model[$] : 32'h0;
        wait_idle(status);
        wb_read(`REG_TOP, top);
        check_value({name, " status"}, exp_status, status);
        check_value({name, " top"}, exp_top, top);
    endtask

    task automatic run_op(input string name, input opcode_e op, input logic [23:0] imm);
        model_apply(op, imm);
        wb_write(`REG_INSTR, {op, imm});
        check_state(name);
    endtask

    task automatic clear_stack(input string name);
        wb_write(`REG_CONTROL, 32'h1);
        model.delete();
        model_error = 1'b0;
        check_state(name);
    endtask

    ////////////////////
    // stimulus.

    initial begin
        int          i;
        int          k;
        opcode_e     op;
        logic [31:0] status;
        logic [23:0] imm;
        imm = 24'($urandom(32'h7db92d5f));
        reset = 1'b1;
        wb_req = '0;
        ack_cycles = 0;
        model_error = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        wb_read(`REG_STATUS, status);
        check_value("status after reset", 32'h0, status);
        run_op("push after reset", OP_PUSH, imm);

        // each pair is consumed so the depth stays low.
        for (i = 0; i < 6; i++) begin
            op = ARITH_OPS[i];
            for (k = 0; k < 4; k++) begin
                run_op("push a", OP_PUSH, rand_imm());
                run_op("push b", OP_PUSH, rand_imm());
                run_op(op.name(), op, 24'h0);
                run_op("pop result", OP_POP, 24'h0);
            end
        end

        run_op("push before dup", OP_PUSH, rand_imm());
        run_op("dup", OP_DUP, 24'h0);
        run_op("nop", OP_NOP, rand_imm());
        run_op("pop after dup", OP_POP, 24'h0);
        run_op("pop reveals entry", OP_POP, 24'h0);

        clear_stack("clear before underflow");
        run_op("pop when empty", OP_POP, 24'h0);
        run_op("push single", OP_PUSH, rand_imm());
        run_op("add underflow", OP_ADD, 24'h0);
        run_op("shl underflow", OP_SHL, 24'h0);

        clear_stack("clear before overflow");
        for (k = 0; k < `STACK_DEPTH; k++) begin
            run_op("fill", OP_PUSH, rand_imm());
        end
        run_op("push overflow", OP_PUSH, rand_imm());
        run_op("dup overflow", OP_DUP, 24'h0);
        clear_stack("clear after overflow");

        // second write lands while the add is still running.
        run_op("push x", OP_PUSH, rand_imm());
        run_op("push y", OP_PUSH, rand_imm());
        imm = rand_imm();
        model_apply(OP_ADD, 24'h0);
        model_apply(OP_PUSH, imm);
        wb_write(`REG_INSTR, {OP_ADD, 24'h0});
        wb_write(`REG_INSTR, {OP_PUSH, imm});
        assert (ack_cycles >= 2) else begin
            abort_run("INSTR write was acknowledged while the unit was busy");
        end
        check_state("add then push");
        model_apply(OP_SUB, 24'h0);
        model_apply(OP_DUP, 24'h0);
        wb_write(`REG_INSTR, {OP_SUB, 24'h0});
        wb_write(`REG_INSTR, {OP_DUP, 24'h0});
        check_state("sub then dup");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+logic
+incdir+verif
logic/stack_pkg.sv
logic/opcode_decoder.sv
logic/operand_stack.sv
logic/stack_alu.sv
logic/host_regs.sv
logic/exec_control.sv
logic/stack_machine_top.sv
verif/stack_machine_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module stack_machine_tb \
    -o stack_machine_sim || { echo "verilator build failed"; exit 1; }
./obj_dir/stack_machine_sim > sim.log 2>&1 || echo "simulator returned nonzero status"
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST RESULT" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
exit 0
